// ==== design/rvIsaPkg.sv ====
// RV64I instruction-set widths, word types and encoding constants shared by the core.
package rvIsaPkg;

    ////////////////////////////////////////
    // Widths and types
    ////////////////////////////////////////
    localparam int xlenW  = 64;                  // Data width.
    localparam int instrW = 32;
    localparam int regAW  = 5;
    localparam int strbW  = xlenW / 8;           // One strobe bit per byte lane.

    typedef logic [xlenW-1:0]  word_t;
    typedef logic [regAW-1:0]  regAddr_t;
    typedef logic [instrW-1:0] instr_t;
    typedef logic [strbW-1:0]  strobe_t;
    typedef logic [6:0]        opcode_t;
    typedef logic [2:0]        funct3_t;

    localparam word_t resetPc   = '0;
    localparam word_t instBytes = 64'd4;         // Fixed 32-bit instruction size.

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////
    localparam opcode_t opOp     = 7'b0110011;
    localparam opcode_t opOpImm  = 7'b0010011;
    localparam opcode_t opLui    = 7'b0110111;
    localparam opcode_t opAuipc  = 7'b0010111;
    localparam opcode_t opJal    = 7'b1101111;
    localparam opcode_t opJalr   = 7'b1100111;
    localparam opcode_t opBranch = 7'b1100011;
    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;

    ////////////////////////////////////////
    // funct3 fields
    ////////////////////////////////////////
    localparam funct3_t f3Beq  = 3'b000;         // Branch kinds.
    localparam funct3_t f3Bne  = 3'b001;
    localparam funct3_t f3Blt  = 3'b100;
    localparam funct3_t f3Bge  = 3'b101;
    localparam funct3_t f3Bltu = 3'b110;
    localparam funct3_t f3Bgeu = 3'b111;

    localparam funct3_t f3Byte  = 3'b000;        // Memory sizes.
    localparam funct3_t f3Word  = 3'b010;
    localparam funct3_t f3Dword = 3'b011;
    localparam funct3_t f3ByteU = 3'b100;

    localparam funct3_t f3Add  = 3'b000;         // Integer ops, sub shares add.
    localparam funct3_t f3Sll  = 3'b001;
    localparam funct3_t f3Slt  = 3'b010;
    localparam funct3_t f3Sltu = 3'b011;
    localparam funct3_t f3Xor  = 3'b100;
    localparam funct3_t f3Srl  = 3'b101;         // Also sra.
    localparam funct3_t f3Or   = 3'b110;
    localparam funct3_t f3And  = 3'b111;

endpackage

// ==== design/ctrlPkg.sv ====
// Control selects and the decoded control word passed from the decoder to the datapath.
package ctrlPkg;
    import rvIsaPkg::*;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt,
        aluSltu, aluSll, aluSrl, aluSra, aluPassB
    } aluOp_e;

    // Conditional kinds all have bit 2 set.
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brEq   = 3'b100,
        brNe   = 3'b101,
        brLt   = 3'b110,                         // Unsigned too, via aluSltu.
        brGe   = 3'b111
    } branch_e;

    typedef enum logic { srcAReg, srcAPc } srcA_e;

    typedef enum logic [1:0] { srcBReg, srcBImm, srcBFour } srcB_e;

    typedef enum logic [2:0] {
        memNone, memLd, memLw, memLbu, memSd, memSw, memSb
    } memOp_e;

    typedef struct packed {
        regAddr_t rd;
        regAddr_t rs1;
        regAddr_t rs2;
        logic     regWen;
        srcA_e    srcA;
        srcB_e    srcB;
        aluOp_e   aluOp;
        branch_e  branch;
        memOp_e   memOp;
        logic     memToReg;                      // Write back load data.
        word_t    imm;
    } ctrl_t;

    localparam ctrl_t ctrlNop = '{rd: '0, rs1: '0, rs2: '0, regWen: 1'b0,
                                  srcA: srcAReg, srcB: srcBReg, aluOp: aluAdd,
                                  branch: brNone, memOp: memNone, memToReg: 1'b0,
                                  imm: '0};

endpackage

// ==== design/regFile.sv ====
// Integer register file for the core, two combinational reads and one clocked write.
`timescale 1ns/100ps

module regFile import rvIsaPkg::*; (
    input  logic     clk,
    input  regAddr_t raAddr,
    input  regAddr_t rbAddr,
    output word_t    raData,
    output word_t    rbData,
    input  regAddr_t wAddr,
    input  word_t    wData,
    input  logic     wen
);
    localparam int numRegs = 2 ** regAW;

    word_t regs [numRegs];                       // Contents undefined until written.

    always_ff @(posedge clk) begin
        if (wen && (wAddr != '0)) begin          // x0 stays zero.
            regs[wAddr] <= wData;
        end
    end

    assign raData = (raAddr == '0) ? '0 : regs[raAddr];
    assign rbData = (rbAddr == '0) ? '0 : regs[rbAddr];

endmodule

// ==== design/alu.sv ====
// 64-bit integer ALU for the execute unit, also gives the zero flag used by branches.
`timescale 1ns/100ps

module alu import rvIsaPkg::*, ctrlPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_e op,
    output word_t  result,
    output logic   zero
);
    logic [5:0] shamt;
    logic       lessS, lessU;

    assign shamt = b[5:0];                       // RV64 shifts use six bits.
    assign lessS = $signed(a) < $signed(b);
    assign lessU = a < b;

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSlt:   result = {{(xlenW-1){1'b0}}, lessS};
            aluSltu:  result = {{(xlenW-1){1'b0}}, lessU};
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSra:   result = word_t'($signed(a) >>> shamt);
            aluPassB: result = b;                // For lui.
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== design/memAlign.sv ====
// Byte-lane alignment between the core and a 64-bit data memory, for stores and loads.
`timescale 1ns/100ps

module memAlign import rvIsaPkg::*, ctrlPkg::*; (
    input  memOp_e  memOp,
    input  word_t   addr,
    input  word_t   wData,
    output word_t   storeData,
    output strobe_t storeStrobe,
    input  word_t   loadData,
    output word_t   rData
);
    logic [2:0] byteOff;
    logic [5:0] bitOff;
    word_t      loadShifted;

    assign byteOff = addr[2:0];                  // Natural alignment assumed.
    assign bitOff  = {byteOff, 3'b000};

    ////////////////////////////////////////
    // Store path
    ////////////////////////////////////////
    assign storeData = wData << bitOff;          // Strobe masks the unused lanes.

    always_comb begin
        case (memOp)
            memSd:   storeStrobe = 8'hFF;
            memSw:   storeStrobe = strobe_t'(8'h0F << byteOff);
            memSb:   storeStrobe = strobe_t'(8'h01 << byteOff);
            default: storeStrobe = '0;
        endcase
    end

    ////////////////////////////////////////
    // Load path
    ////////////////////////////////////////
    assign loadShifted = loadData >> bitOff;

    always_comb begin
        case (memOp)
            memLw:   rData = {{32{loadShifted[31]}}, loadShifted[31:0]};  // Sign extend.
            memLbu:  rData = {56'b0, loadShifted[7:0]};
            default: rData = loadData;
        endcase
    end

endmodule

// ==== design/pcUnit.sv ====
// Program counter and next-address logic, picks base and offset from the branch kind.
`timescale 1ns/100ps

module pcUnit import rvIsaPkg::*, ctrlPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  branch_e branch,
    input  logic    zero,
    input  logic    cmpBit,                      // Bit 0 of slt or sltu.
    input  word_t   imm,
    input  word_t   rs1Val,
    output word_t   pc
);
    logic  useRs1, useImm;
    word_t sum;

    always_comb begin
        useRs1 = 1'b0;                           // Base is pc unless jalr.
        case (branch)
            brJal:   useImm = 1'b1;
            brJalr: begin
                useRs1 = 1'b1;
                useImm = 1'b1;
            end
            brEq:    useImm = zero;
            brNe:    useImm = ~zero;
            brLt:    useImm = cmpBit;
            brGe:    useImm = ~cmpBit;
            default: useImm = 1'b0;
        endcase
    end

    assign sum = (useRs1 ? rs1Val : pc) + (useImm ? imm : instBytes);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= {sum[xlenW-1:1], 1'b0};        // Clears bit 0 of a jalr sum.
        end
    end

endmodule

// ==== design/execUnit.sv ====
// Execute unit of the single-cycle core, operand and write-back muxes around the datapath.
`timescale 1ns/100ps

module execUnit import rvIsaPkg::*, ctrlPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  ctrl_t   ctrl,
    output word_t   pc,
    output word_t   dataAddr,
    output word_t   storeData,
    output strobe_t storeStrobe,
    input  word_t   loadData
);
    word_t busA, busB;
    word_t aluA, aluB, aluRes;
    word_t memData, wbData;
    logic  aluZero;

    ////////////////////////////////////////
    // Operand and write-back selection
    ////////////////////////////////////////
    assign aluA = (ctrl.srcA == srcAPc) ? pc : busA;

    always_comb begin
        case (ctrl.srcB)
            srcBImm:  aluB = ctrl.imm;
            srcBFour: aluB = instBytes;          // Link address for jumps.
            default:  aluB = busB;
        endcase
    end

    assign wbData   = ctrl.memToReg ? memData : aluRes;
    assign dataAddr = aluRes;

    regFile uRegFile (
        .clk(clk), .raAddr(ctrl.rs1), .rbAddr(ctrl.rs2),
        .raData(busA), .rbData(busB),
        .wAddr(ctrl.rd), .wData(wbData), .wen(ctrl.regWen)
    );

    alu uAlu (.a(aluA), .b(aluB), .op(ctrl.aluOp), .result(aluRes), .zero(aluZero));

    memAlign uMemAlign (
        .memOp(ctrl.memOp), .addr(aluRes), .wData(busB),
        .storeData(storeData), .storeStrobe(storeStrobe),
        .loadData(loadData), .rData(memData)
    );

    pcUnit uPcUnit (
        .clk(clk), .rstN(rstN), .branch(ctrl.branch),
        .zero(aluZero), .cmpBit(aluRes[0]),
        .imm(ctrl.imm), .rs1Val(busA), .pc(pc)
    );

endmodule

// ==== design/instDecode.sv ====
// Instruction decoder, turns one RV64I instruction word into the datapath control word.
`timescale 1ns/100ps

module instDecode import rvIsaPkg::*, ctrlPkg::*; (
    input  logic   rstN,
    input  instr_t instr,
    output ctrl_t  ctrl
);
    opcode_t opcode;
    funct3_t funct3;
    word_t   immI, immS, immB, immU, immJ;

    // Maps funct3 to an ALU op; alt picks sub or sra.
    function automatic aluOp_e aluFromFunct(funct3_t f3, logic alt);
        aluOp_e op;
        case (f3)
            f3Add:   op = alt ? aluSub : aluAdd;
            f3Sll:   op = aluSll;
            f3Slt:   op = aluSlt;
            f3Sltu:  op = aluSltu;
            f3Xor:   op = aluXor;
            f3Srl:   op = alt ? aluSra : aluSrl;
            f3Or:    op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    ////////////////////////////////////////
    // Immediates
    ////////////////////////////////////////
    assign immI = {{52{instr[31]}}, instr[31:20]};   // Low six bits are shamt.
    assign immS = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign immJ = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = ctrlNop;                              // Reset and unknown opcodes.
        if (rstN) begin
            ctrl.rd  = instr[11:7];
            ctrl.rs1 = instr[19:15];
            ctrl.rs2 = instr[24:20];
            case (opcode)
                opOp: begin
                    ctrl.regWen = 1'b1;
                    ctrl.aluOp  = aluFromFunct(funct3, instr[30]);
                end
                opOpImm: begin
                    ctrl.regWen = 1'b1;
                    ctrl.srcB   = srcBImm;
                    ctrl.imm    = immI;
                    ctrl.aluOp  = aluFromFunct(funct3, (funct3 == f3Srl) && instr[30]);
                end
                opLui: begin
                    ctrl.regWen = 1'b1;
                    ctrl.srcB   = srcBImm;
                    ctrl.aluOp  = aluPassB;
                    ctrl.imm    = immU;
                end
                opAuipc: begin
                    ctrl.regWen = 1'b1;
                    ctrl.srcA   = srcAPc;
                    ctrl.srcB   = srcBImm;
                    ctrl.imm    = immU;
                end
                opJal, opJalr: begin
                    ctrl.regWen = 1'b1;
                    ctrl.srcA   = srcAPc;                // Link is pc plus four.
                    ctrl.srcB   = srcBFour;
                    ctrl.branch = (opcode == opJal) ? brJal : brJalr;
                    ctrl.imm    = (opcode == opJal) ? immJ : immI;
                end
                opBranch: begin
                    ctrl.imm = immB;
                    case (funct3)
                        f3Beq:   begin ctrl.aluOp = aluSub;  ctrl.branch = brEq; end
                        f3Bne:   begin ctrl.aluOp = aluSub;  ctrl.branch = brNe; end
                        f3Blt:   begin ctrl.aluOp = aluSlt;  ctrl.branch = brLt; end
                        f3Bge:   begin ctrl.aluOp = aluSlt;  ctrl.branch = brGe; end
                        f3Bltu:  begin ctrl.aluOp = aluSltu; ctrl.branch = brLt; end
                        f3Bgeu:  begin ctrl.aluOp = aluSltu; ctrl.branch = brGe; end
                        default: ctrl.branch = brNone;
                    endcase
                end
                opLoad: begin
                    ctrl.srcB     = srcBImm;
                    ctrl.imm      = immI;
                    ctrl.memToReg = 1'b1;
                    ctrl.memOp    = (funct3 == f3Dword) ? memLd :
                                    (funct3 == f3Word)  ? memLw :
                                    (funct3 == f3ByteU) ? memLbu : memNone;
                    ctrl.regWen   = (ctrl.memOp != memNone);
                end
                opStore: begin
                    ctrl.srcB  = srcBImm;
                    ctrl.imm   = immS;
                    ctrl.memOp = (funct3 == f3Dword) ? memSd :
                                 (funct3 == f3Word)  ? memSw :
                                 (funct3 == f3Byte)  ? memSb : memNone;
                end
                default: ctrl = ctrlNop;
            endcase
        end
    end

endmodule

// ==== design/rvCore.sv ====
// Top of the single-cycle RV64I core, joins the decoder to the execute unit.
`timescale 1ns/100ps

module rvCore import rvIsaPkg::*, ctrlPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  instr_t  instr,                       // Fetched from pc in the same cycle.
    output word_t   pc,
    output word_t   dataAddr,
    output word_t   storeData,
    output strobe_t storeStrobe,
    input  word_t   loadData                     // Answered in the same cycle.
);
    ctrl_t ctrl;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    instDecode uDecode (
        .rstN  (rstN),
        .instr (instr),
        .ctrl  (ctrl)
    );

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////
    execUnit uExec (
        .clk         (clk),
        .rstN        (rstN),
        .ctrl        (ctrl),
        .pc          (pc),
        .dataAddr    (dataAddr),
        .storeData   (storeData),
        .storeStrobe (storeStrobe),
        .loadData    (loadData)
    );

endmodule

// ==== verification/coreTb.sv ====
// Simulation top that runs a ROM program on the RV64I core and checks every cycle against a trace table.
`timescale 1ns/100ps

module coreTb import rvIsaPkg::*; ();
    localparam int clkPeriod   = 100;
    localparam int resetCycles = 4;
    localparam int romWords    = 64;
    localparam int memWords    = 32;
    localparam logic [1:0] dLit  = 2'd0;         // Data is a literal.
    localparam logic [1:0] dWord = 2'd1;         // Whole preloaded word.
    localparam logic [1:0] dSext = 2'd2;         // Sign-extended 32-bit lane.
    localparam logic [1:0] dZext = 2'd3;         // Zero-extended byte.

    typedef struct packed {
        word_t      pc;
        strobe_t    strobe;
        word_t      addr;
        logic [1:0] kind;
        word_t      data;                        // Source byte address unless dLit.
    } row_t;

    logic    clk, rstN;
    instr_t  instr;
    word_t   pc, dataAddr, storeData, loadData;
    strobe_t storeStrobe;
    instr_t  rom [romWords];
    word_t   dmem [memWords];
    word_t   initWords [memWords];               // Preload copy for expected loads.
    row_t    trace [$];
    bit      tableBuilt = 1'b0;
    int      pcErrors, strobeErrors, addrErrors, dataErrors;

    rvCore dut (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .dataAddr(dataAddr),
        .storeData(storeData), .storeStrobe(storeStrobe), .loadData(loadData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Data memory model
    ////////////////////////////////////////
    assign loadData = dmem[dataAddr[7:3]];       // Same-cycle answer.

    always @(posedge clk) begin
        for (int i = 0; i < strbW; i++) begin
            if (storeStrobe[i]) begin
                dmem[dataAddr[7:3]][i*8 +: 8] <= storeData[i*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic instr_t encR(int f7, int rs2, int rs1, funct3_t f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3, rd[4:0], opOp};
    endfunction

    function automatic instr_t encI(int imm, int rs1, funct3_t f3, int rd, opcode_t op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic instr_t encS(int imm, int rs2, int rs1, funct3_t f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], opStore};
    endfunction

    function automatic instr_t encB(int imm, int rs2, int rs1, funct3_t f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic instr_t encU(int imm, int rd, opcode_t op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic instr_t encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
    endfunction

    // Places an instruction and adds the row expected while it executes.
    task automatic step(int p, instr_t code, strobe_t st = '0, word_t ad = '0,
                        logic [1:0] k = dLit, word_t d = '0);
        rom[p[7:2]] = code;
        trace.push_back('{pc: word_t'(p), strobe: st, addr: ad, kind: k, data: d});
    endtask

    task automatic storeRow(int p, int rs, logic [1:0] k, word_t d);
        step(p, encS(64, rs, 0, f3Dword), 8'hFF, 64'h40, k, d);
    endtask

    ////////////////////////////////////////
    // Program and trace table
    ////////////////////////////////////////
    task automatic buildProgram();
        word_t a;
        word_t b;
        a = 64'd100;
        b = 64'hFFFF_FFFF_FFFF_FFF9;             // Minus seven.
        step('h00, encI(100, 0, f3Add, 1, opOpImm));
        step('h04, encI(-7, 0, f3Add, 2, opOpImm));
        step('h08, encR(0, 2, 1, f3Add, 3));
        storeRow('h0C, 3, dLit, a + b);
        step('h10, encR(32, 1, 2, f3Add, 4));    // Sub.
        storeRow('h14, 4, dLit, b - a);
        step('h18, encR(0, 2, 1, f3Xor, 5));
        storeRow('h1C, 5, dLit, a ^ b);
        step('h20, encR(0, 2, 1, f3Or, 6));
        storeRow('h24, 6, dLit, a | b);
        step('h28, encR(0, 2, 1, f3And, 7));
        storeRow('h2C, 7, dLit, a & b);
        step('h30, encR(0, 1, 2, f3Slt, 8));
        storeRow('h34, 8, dLit, 64'd1);           // Minus seven is less when signed.
        step('h38, encR(0, 1, 2, f3Sltu, 9));
        storeRow('h3C, 9, dLit, 64'd0);
        step('h40, encI(40, 1, f3Sll, 10, opOpImm));
        storeRow('h44, 10, dLit, a << 40);
        step('h48, encR(0, 8, 2, f3Srl, 11));    // Shift by x8, which holds one.
        storeRow('h4C, 11, dLit, b >> 1);
        step('h50, encR(32, 8, 2, f3Srl, 12));   // Sra.
        storeRow('h54, 12, dLit, 64'hFFFF_FFFF_FFFF_FFFC);
        step('h58, encR(0, 1, 2, f3Sll, 13));    // 100 mod 64 gives 36.
        storeRow('h5C, 13, dLit, b << 36);
        step('h60, encU('hABCDE, 14, opLui));
        storeRow('h64, 14, dLit, 64'hFFFF_FFFF_ABCD_E000);
        step('h68, encI(5, 0, f3Add, 0, opOpImm));
        storeRow('h6C, 0, dLit, 64'd0);
        step('h70, encB(8, 1, 1, f3Beq));        // Taken.
        step('h78, encB(8, 2, 1, f3Beq));
        step('h7C, encB(8, 2, 1, f3Bne));        // Taken.
        step('h84, encB(8, 1, 1, f3Bne));
        step('h88, encB(8, 1, 2, f3Blt));        // Taken.
        step('h90, encB(8, 1, 2, f3Bge));
        step('h94, encB(8, 1, 2, f3Bltu));       // Unsigned order differs.
        step('h98, encB(8, 1, 2, f3Bgeu));       // Taken.
        step('hA0, encB(8, 2, 1, f3Bge));        // Taken.
        step('hA8, encB(8, 2, 1, f3Blt));
        step('hAC, encJ(12, 16));
        storeRow('hB8, 16, dLit, 64'hB0);
        step('hBC, encU(0, 17, opAuipc));
        step('hC0, encI(13, 17, f3Add, 18, opJalr));  // Odd sum lands on 0xC8.
        storeRow('hC8, 18, dLit, 64'hC4);
        step('hCC, encU(2, 19, opAuipc));
        storeRow('hD0, 19, dLit, 64'hCC + 64'h2000);
        step('hD4, encI(128, 0, f3Dword, 20, opLoad));
        storeRow('hD8, 20, dWord, 64'd128);
        step('hDC, encI(140, 0, f3Word, 21, opLoad));
        storeRow('hE0, 21, dSext, 64'd140);
        step('hE4, encI(147, 0, f3ByteU, 22, opLoad));
        storeRow('hE8, 22, dZext, 64'd147);
        step('hEC, encS(76, 3, 0, f3Word), 8'hF0, 64'h4C, dLit, (a + b) << 32);
        step('hF0, encS(75, 4, 0, f3Byte), 8'h08, 64'h4B, dLit, (b - a) << 24);
        step('hF4, encS(78, 1, 0, f3Byte), 8'h40, 64'h4E, dLit, a << 48);
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    function automatic word_t expectedData(row_t r);
        word_t       w;
        int          off;
        logic [31:0] wordLane;
        logic [7:0]  byteLane;
        w   = initWords[r.data[7:3]];
        off = r.data[2:0];
        case (r.kind)
            dWord:   return w;
            dSext: begin
                wordLane = w[off*8 +: 32];       // Four bytes from the addressed one up.
                return {{32{wordLane[31]}}, wordLane};
            end
            dZext: begin
                byteLane = w[off*8 +: 8];
                return {56'b0, byteLane};
            end
            default: return r.data;
        endcase
    endfunction

    task automatic checkOutputs(row_t r);
        word_t mask;
        word_t expData;
        for (int i = 0; i < strbW; i++) begin
            mask[i*8 +: 8] = {8{r.strobe[i]}};   // Only written lanes count.
        end
        expData = expectedData(r);
        assert (pc === r.pc) else begin
            pcErrors++;
            $display("MISMATCH at %0t: pc is %h, expected %h", $time, pc, r.pc);
        end
        assert (storeStrobe === r.strobe) else begin
            strobeErrors++;
            $display("MISMATCH at %0t: storeStrobe is %h, expected %h",
                     $time, storeStrobe, r.strobe);
        end
        if (r.strobe != '0) begin
            assert (dataAddr === r.addr) else begin
                addrErrors++;
                $display("MISMATCH at %0t: dataAddr is %h, expected %h",
                         $time, dataAddr, r.addr);
            end
            assert ((storeData & mask) === (expData & mask)) else begin
                dataErrors++;
                $display("MISMATCH at %0t: storeData is %h, expected %h under strobe %h",
                         $time, storeData, expData, r.strobe);
            end
        end
    endtask

    initial begin
        wait (tableBuilt);
        #((resetCycles + trace.size() + 20) * clkPeriod);
        $display("Timeout: the core did not get through the trace table in time.");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        word_t w;
        void'($urandom(32'hc78f_94f8));
        rstN  = 1'b0;
        instr = encS(64, 0, 0, f3Dword);         // A store that reset has to suppress.
        for (int i = 0; i < memWords; i++) begin
            w            = {$urandom, $urandom};
            dmem[i]     <= w;
            initWords[i] = w;
        end
        for (int i = 0; i < romWords; i++) begin
            rom[i] = encI(0, 0, f3Add, 0, opOpImm);   // Nop fill.
        end
        buildProgram();
        tableBuilt = 1'b1;
        // The first row starts on the falling edge that ends the last reset cycle.
        for (int i = 0; i < resetCycles - 1; i++) begin
            @(negedge clk);
            #(clkPeriod / 4);
            checkOutputs(row_t'('0));            // Pc and strobe held at zero.
        end
        for (int r = 0; r < trace.size(); r++) begin
            @(negedge clk);
            rstN  = 1'b1;
            instr = rom[pc[7:2]];
            #(clkPeriod / 4);
            checkOutputs(trace[r]);
        end
        $display("Errors: pc %0d, strobe %0d, address %0d, data %0d",
                 pcErrors, strobeErrors, addrErrors, dataErrors);
        if (pcErrors + strobeErrors + addrErrors + dataErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/rvIsaPkg.sv
design/ctrlPkg.sv
design/regFile.sv
design/alu.sv
design/memAlign.sv
design/pcUnit.sv
design/execUnit.sv
design/instDecode.sv
design/rvCore.sv
verification/coreTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = coreTb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
